/* verilog.f */
+incdir+tb
common/rom_pkg.sv
source/snes_bus_sync.sv
source/snes_liveness.sv
rom_ctrl/rom_req_port.sv
rom_ctrl/rom_arbiter.sv
rom_ctrl/rom_bus_mux.sv
source/cart_mem_core.sv
tb/tb_cart_mem_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps
TOP       = tb_cart_mem_core
FILELIST  = verilog.f
MDIR      = obj_dir
LOG       = sim.log

SOURCES   = $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS   = $(wildcard tb/*.svh)
BIN       = $(MDIR)/$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -o $(TOP) -f $(FILELIST)

# pass or fail comes from the log
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)

/* tb/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////////////////////////
// error counters and compare tasks
////////////////////////////////////////////////////////////

// wrong values seen by the compare tasks
int value_errors = 0;
// timeouts and other protocol trouble
int other_errors = 0;

// one byte of read data or memory contents
task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
  if (actual !== expected) begin
    value_errors++;
    $display("** Error %s: expected %h, actual %h", name, expected, actual);
  end
endtask

// single control level
task automatic check_bit(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    value_errors++;
    $display("** Error %s: expected %b, actual %b", name, expected, actual);
  end
endtask

// anything that is not a plain value mismatch
task automatic report_failure(input string what);
  other_errors++;
  $display("failure at %0t ns: %s", $time, what);
endtask

`endif

/* tb/tb_cart_mem_core.sv */
`timescale 1ns/10ps

module tb_cart_mem_core import rom_pkg::*; ();

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 16;
  localparam int DEAD_TIMEOUT  = 64;
  localparam int ROM_CYCLE_LEN = 6;
  // console clock half period in CLK2 cycles
  localparam int CPU_HALF      = 6;
  // longest wait for one ready over several console cycles
  localparam int WAIT_LIMIT    = 20 * CPU_HALF + 4 * (ROM_CYCLE_LEN + 2);
  // filtered address lags 7 cycles
  localparam int FILTER_WAIT   = 10;
  // model holds 1k words
  localparam int MEM_AW        = 10;
  // console mapping covers half of the model
  localparam snes_addr_t ROM_MASK = 24'h0003FF;

  // rough cycle count of the whole sequence
  localparam int TEST_CYCLES = RESET_CYCLES + 4
    + (WAIT_LIMIT + 4)
    + 2 * (WAIT_LIMIT + 4)
    + (2 * WAIT_LIMIT + 4)
    + (WAIT_LIMIT + 8 * CPU_HALF + 2 * FILTER_WAIT + 4)
    + (WAIT_LIMIT + 4);
  localparam int WATCHDOG_NS = (TEST_CYCLES + TEST_CYCLES / 4) * CLK_PERIOD;

  logic       CLK2          = 1'b0;
  logic       arst_n        = 1'b0;
  snes_addr_t snes_addr     = '0;
  logic       snes_rd_n     = 1'b1;
  logic       snes_wr_n     = 1'b1;
  logic       snes_romsel_n = 1'b1;
  logic       snes_cpu_clk  = 1'b0;
  snes_addr_t rom_mask      = ROM_MASK;
  logic       mcu_rrq       = 1'b0;
  logic       mcu_wrq       = 1'b0;
  snes_addr_t mcu_addr      = '0;
  byte_t      mcu_wdata     = '0;
  logic       cop_active    = 1'b0;
  logic       cop_rrq       = 1'b0;
  logic       cop_wrq       = 1'b0;
  snes_addr_t cop_addr      = '0;
  byte_t      cop_wdata     = '0;
  byte_t      mcu_rdata;
  logic       mcu_rdy;
  byte_t      cop_rdata;
  logic       cop_rdy;
  rom_addr_t  rom_addr;
  rom_word_t  rom_data_out;
  logic       rom_data_oe;
  logic       rom_we_n;
  logic       rom_bhe_n;
  logic       rom_ble_n;
  rom_word_t  rom_data_in;
  byte_t      snes_data_out;
  logic       snes_data_oe;
  logic       snes_reset_strobe;

  // console clock generator state
  logic       cpu_clk_run   = 1'b0;
  int         cpu_div       = 0;
  int         strobe_count  = 0;

  // psram model
  rom_word_t  rom_mem [2**MEM_AW];
  logic       preloaded     = 1'b0;
  integer     seed          = 67404;

  `include "tb_checks.svh"

  always #(CLK_PERIOD / 2) CLK2 = ~CLK2;

  cart_mem_core #(
    .DEAD_TIMEOUT  (DEAD_TIMEOUT),
    .ROM_CYCLE_LEN (ROM_CYCLE_LEN)
  ) cart_mem_core_i (
    .CLK2              (CLK2),
    .arst_n            (arst_n),
    .snes_addr         (snes_addr),
    .snes_rd_n         (snes_rd_n),
    .snes_wr_n         (snes_wr_n),
    .snes_romsel_n     (snes_romsel_n),
    .snes_cpu_clk      (snes_cpu_clk),
    .rom_mask          (rom_mask),
    .mcu_rrq           (mcu_rrq),
    .mcu_wrq           (mcu_wrq),
    .mcu_addr          (mcu_addr),
    .mcu_wdata         (mcu_wdata),
    .mcu_rdata         (mcu_rdata),
    .mcu_rdy           (mcu_rdy),
    .cop_active        (cop_active),
    .cop_rrq           (cop_rrq),
    .cop_wrq           (cop_wrq),
    .cop_addr          (cop_addr),
    .cop_wdata         (cop_wdata),
    .cop_rdata         (cop_rdata),
    .cop_rdy           (cop_rdy),
    .rom_addr          (rom_addr),
    .rom_data_out      (rom_data_out),
    .rom_data_oe       (rom_data_oe),
    .rom_we_n          (rom_we_n),
    .rom_bhe_n         (rom_bhe_n),
    .rom_ble_n         (rom_ble_n),
    .rom_data_in       (rom_data_in),
    .snes_data_out     (snes_data_out),
    .snes_data_oe      (snes_data_oe),
    .snes_reset_strobe (snes_reset_strobe)
  );

  ////////////////////////////////////////////////////////////
  // psram model and console clock
  ////////////////////////////////////////////////////////////

  // asynchronous read on the low address bits
  assign rom_data_in = rom_mem[rom_addr[MEM_AW-1:0]];

  // random preload on the first edge
  // later edges take lane writes while the data bus is driven
  always @(posedge CLK2) begin
    if (!preloaded) begin
      for (int i = 0; i < 2**MEM_AW; i++) begin
        rom_mem[i] <= rom_word_t'($random(seed));
      end
      preloaded <= 1'b1;
    end else if (!rom_we_n && rom_data_oe) begin
      if (!rom_ble_n) rom_mem[rom_addr[MEM_AW-1:0]][7:0] <= rom_data_out[7:0];
      if (!rom_bhe_n) rom_mem[rom_addr[MEM_AW-1:0]][15:8] <= rom_data_out[15:8];
    end
  end

  // console cpu clock held low while stopped
  always @(posedge CLK2) begin
    if (!cpu_clk_run) begin
      cpu_div      <= 0;
      snes_cpu_clk <= 1'b0;
    end else if (cpu_div == CPU_HALF - 1) begin
      cpu_div      <= 0;
      snes_cpu_clk <= ~snes_cpu_clk;
    end else begin
      cpu_div <= cpu_div + 1;
    end
  end

  // count reset strobes away from the edge
  always @(negedge CLK2) begin
    if (snes_reset_strobe) strobe_count <= strobe_count + 1;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // model word behind a byte address
  function automatic rom_word_t word_at(input snes_addr_t a);
    return rom_mem[a[MEM_AW:1]];
  endfunction

  // odd address reads the low byte
  function automatic byte_t model_byte(input snes_addr_t a);
    rom_word_t w;
    w = word_at(a);
    return a[0] ? w[7:0] : w[15:8];
  endfunction

  // sets one request pulse from a rising edge
  task automatic issue_request(input req_src_t src, input logic write,
                               input snes_addr_t addr, input byte_t data);
    if (src == cop) begin
      cop_addr  <= addr;
      cop_wdata <= data;
      cop_rrq   <= !write;
      cop_wrq   <= write;
    end else begin
      mcu_addr  <= addr;
      mcu_wdata <= data;
      mcu_rrq   <= !write;
      mcu_wrq   <= write;
    end
  endtask

  task automatic clear_requests;
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
    cop_rrq <= 1'b0;
    cop_wrq <= 1'b0;
  endtask

  // one-cycle pulse for a single requester
  task automatic pulse_request(input req_src_t src, input logic write,
                               input snes_addr_t addr, input byte_t data);
    @(posedge CLK2);
    issue_request(src, write, addr, data);
    @(posedge CLK2);
    clear_requests();
  endtask

  task automatic wait_ready(input req_src_t src, input string name);
    int   n;
    logic rdy;
    n   = 0;
    rdy = 1'b0;
    while (!rdy && n < WAIT_LIMIT) begin
      @(negedge CLK2);
      rdy = (src == cop) ? cop_rdy : mcu_rdy;
      n++;
    end
    if (!rdy) report_failure({name, ": ready did not return within the wait limit"});
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_state;
    @(negedge CLK2);
    check_bit("reset mcu_rdy", 1'b1, mcu_rdy);
    check_bit("reset cop_rdy", 1'b1, cop_rdy);
    check_bit("reset rom_we_n", 1'b1, rom_we_n);
    check_bit("reset rom_data_oe", 1'b0, rom_data_oe);
    check_bit("reset snes_reset_strobe", 1'b0, snes_reset_strobe);
    check_bit("reset snes_data_oe", 1'b0, snes_data_oe);
  endtask

  // console clock stays low so the core sees it dead
  task automatic test_dead_read;
    snes_addr_t addr;
    addr = 24'h000131;
    pulse_request(mcu, 1'b0, addr, 8'h00);
    @(negedge CLK2);
    check_bit("dead_read ready low", 1'b0, mcu_rdy);
    wait_ready(mcu, "dead_read");
    check_byte("dead_read mcu_rdata", model_byte(addr), mcu_rdata);
  endtask

  // one write per lane with the other lane unchanged
  task automatic test_dead_write;
    snes_addr_t addr_lo;
    snes_addr_t addr_hi;
    rom_word_t  old_w;
    rom_word_t  new_w;
    addr_lo = 24'h000245;
    addr_hi = 24'h000378;
    old_w = word_at(addr_lo);
    pulse_request(mcu, 1'b1, addr_lo, 8'hA5);
    wait_ready(mcu, "dead_write low lane");
    new_w = word_at(addr_lo);
    check_byte("dead_write low lane", 8'hA5, new_w[7:0]);
    check_byte("dead_write high lane kept", old_w[15:8], new_w[15:8]);
    old_w = word_at(addr_hi);
    pulse_request(mcu, 1'b1, addr_hi, 8'h3C);
    wait_ready(mcu, "dead_write high lane");
    new_w = word_at(addr_hi);
    check_byte("dead_write high lane", 8'h3C, new_w[15:8]);
    check_byte("dead_write low lane kept", old_w[7:0], new_w[7:0]);
  endtask

  task automatic test_cop_priority;
    snes_addr_t mcu_a;
    snes_addr_t cop_a;
    int         n;
    int         cop_at;
    int         mcu_at;
    mcu_a = 24'h0004E0;
    cop_a = 24'h000511;
    @(posedge CLK2);
    cop_active <= 1'b1;
    issue_request(cop, 1'b0, cop_a, 8'h00);
    issue_request(mcu, 1'b0, mcu_a, 8'h00);
    @(posedge CLK2);
    clear_requests();
    cop_at = -1;
    mcu_at = -1;
    // note the cycle each ready comes back
    for (n = 0; n < 2 * WAIT_LIMIT && (cop_at < 0 || mcu_at < 0); n++) begin
      @(negedge CLK2);
      if (cop_at < 0 && cop_rdy) cop_at = n;
      if (mcu_at < 0 && mcu_rdy) mcu_at = n;
    end
    if (cop_at < 0 || mcu_at < 0) begin
      report_failure("cop_priority: a ready output never returned high");
    end
    check_bit("cop_priority cop first", 1'b1, (cop_at >= 0) && (mcu_at > cop_at));
    check_byte("cop_priority cop_rdata", model_byte(cop_a), cop_rdata);
    check_byte("cop_priority mcu_rdata", model_byte(mcu_a), mcu_rdata);
    @(posedge CLK2);
    cop_active <= 1'b0;
  endtask

  task automatic test_revival;
    snes_addr_t con_a;
    int         n;
    // bit 10 lies outside the mask
    con_a = 24'hC12745;
    @(posedge CLK2);
    snes_addr   <= con_a;
    cpu_clk_run <= 1'b1;
    n = 0;
    while (strobe_count == 0 && n < WAIT_LIMIT) begin
      @(negedge CLK2);
      n++;
    end
    if (strobe_count == 0) report_failure("revival: reset strobe never fired");
    // a second strobe would show up within several console cycles
    repeat (8 * CPU_HALF) @(negedge CLK2);
    check_byte("revival strobe count", 8'd1, byte_t'(strobe_count));
    // console rom read with the port idle
    @(posedge CLK2);
    snes_romsel_n <= 1'b0;
    snes_rd_n     <= 1'b0;
    repeat (FILTER_WAIT) @(posedge CLK2);
    @(negedge CLK2);
    check_bit("revival snes_data_oe", 1'b1, snes_data_oe);
    check_byte("revival snes_data_out", model_byte(con_a & ROM_MASK), snes_data_out);
    @(posedge CLK2);
    snes_romsel_n <= 1'b1;
    snes_rd_n     <= 1'b1;
    repeat (FILTER_WAIT) @(posedge CLK2);
  endtask

  // console keeps running and the mcu waits for free slots
  task automatic test_alive_read;
    snes_addr_t addr;
    addr = 24'h0002AA;
    pulse_request(mcu, 1'b0, addr, 8'h00);
    wait_ready(mcu, "alive_read");
    check_byte("alive_read mcu_rdata", model_byte(addr), mcu_rdata);
  endtask

  ////////////////////////////////////////////////////////////
  // sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    repeat (RESET_CYCLES) @(posedge CLK2);
    arst_n <= 1'b1;
    test_reset_state();
    test_dead_read();
    test_dead_write();
    test_cop_priority();
    test_revival();
    test_alive_read();
    @(negedge CLK2);
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, test sequence did not complete", WATCHDOG_NS);
    $display("Finished with errors");
    $finish;
  end

endmodule

/* source/cart_mem_core.sv */
`timescale 1ns/10ps

module cart_mem_core import rom_pkg::*; #(
  parameter int unsigned DEAD_TIMEOUT  = 96000,
  parameter int unsigned ROM_CYCLE_LEN = 6
) (
  input  logic       CLK2,
  input  logic       arst_n,
  // console bus
  input  snes_addr_t snes_addr,
  input  logic       snes_rd_n,
  input  logic       snes_wr_n,
  input  logic       snes_romsel_n,
  input  logic       snes_cpu_clk,
  input  snes_addr_t rom_mask,
  // mcu requester
  input  logic       mcu_rrq,
  input  logic       mcu_wrq,
  input  snes_addr_t mcu_addr,
  input  byte_t      mcu_wdata,
  output byte_t      mcu_rdata,
  output logic       mcu_rdy,
  // coprocessor requester
  input  logic       cop_active,
  input  logic       cop_rrq,
  input  logic       cop_wrq,
  input  snes_addr_t cop_addr,
  input  byte_t      cop_wdata,
  output byte_t      cop_rdata,
  output logic       cop_rdy,
  // psram
  output rom_addr_t  rom_addr,
  output rom_word_t  rom_data_out,
  output logic       rom_data_oe,
  output logic       rom_we_n,
  output logic       rom_bhe_n,
  output logic       rom_ble_n,
  input  rom_word_t  rom_data_in,
  // console read data
  output byte_t      snes_data_out,
  output logic       snes_data_oe,
  output logic       snes_reset_strobe
);

  snes_addr_t addr_f;
  logic       rd_n_f;
  logic       romsel_n_f;
  logic       cpu_clk_raw;
  logic       cycle_start;
  logic       cycle_end;
  logic       snes_dead;
  logic       rom_hit;
  snes_addr_t mcu_addr_q;
  snes_addr_t cop_addr_q;
  byte_t      mcu_wdata_q;
  byte_t      cop_wdata_q;
  byte_t      rd_byte;
  logic       mcu_rd_pend;
  logic       mcu_wr_pend;
  logic       cop_rd_pend;
  logic       cop_wr_pend;
  logic       mcu_done;
  logic       cop_done;
  logic       capture;
  req_src_t   grant_src;
  logic       grant_valid;
  logic       grant_write;

  ////////////////////////////////////////////////////////////
  // console side
  ////////////////////////////////////////////////////////////

  // write strobe and filtered clock have no user here
  snes_bus_sync snes_bus_sync_i (
    .CLK2          (CLK2),
    .arst_n        (arst_n),
    .snes_addr     (snes_addr),
    .snes_rd_n     (snes_rd_n),
    .snes_wr_n     (snes_wr_n),
    .snes_romsel_n (snes_romsel_n),
    .snes_cpu_clk  (snes_cpu_clk),
    .addr_f        (addr_f),
    .rd_n_f        (rd_n_f),
    .wr_n_f        (),
    .romsel_n_f    (romsel_n_f),
    .cpu_clk_f     (),
    .cpu_clk_raw   (cpu_clk_raw),
    .cycle_start   (cycle_start),
    .cycle_end     (cycle_end)
  );

  snes_liveness #(
    .DEAD_TIMEOUT (DEAD_TIMEOUT)
  ) snes_liveness_i (
    .CLK2              (CLK2),
    .arst_n            (arst_n),
    .cpu_clk_raw       (cpu_clk_raw),
    .snes_dead         (snes_dead),
    .snes_reset_strobe (snes_reset_strobe)
  );

  ////////////////////////////////////////////////////////////
  // requesters
  ////////////////////////////////////////////////////////////

  // capture only reaches the granted port
  rom_req_port mcu_port_i (
    .CLK2    (CLK2),
    .arst_n  (arst_n),
    .rrq     (mcu_rrq),
    .wrq     (mcu_wrq),
    .addr_in (mcu_addr),
    .wdata   (mcu_wdata),
    .done    (mcu_done),
    .capture (capture && (grant_src == mcu)),
    .rd_byte (rd_byte),
    .rd_pend (mcu_rd_pend),
    .wr_pend (mcu_wr_pend),
    .rdy     (mcu_rdy),
    .addr_q  (mcu_addr_q),
    .wdata_q (mcu_wdata_q),
    .rdata   (mcu_rdata)
  );

  rom_req_port cop_port_i (
    .CLK2    (CLK2),
    .arst_n  (arst_n),
    .rrq     (cop_rrq),
    .wrq     (cop_wrq),
    .addr_in (cop_addr),
    .wdata   (cop_wdata),
    .done    (cop_done),
    .capture (capture && (grant_src == cop)),
    .rd_byte (rd_byte),
    .rd_pend (cop_rd_pend),
    .wr_pend (cop_wr_pend),
    .rdy     (cop_rdy),
    .addr_q  (cop_addr_q),
    .wdata_q (cop_wdata_q),
    .rdata   (cop_rdata)
  );

  ////////////////////////////////////////////////////////////
  // arbitration and rom port
  ////////////////////////////////////////////////////////////

  rom_arbiter #(
    .ROM_CYCLE_LEN (ROM_CYCLE_LEN)
  ) rom_arbiter_i (
    .CLK2        (CLK2),
    .arst_n      (arst_n),
    .cop_active  (cop_active),
    .cop_rd_pend (cop_rd_pend),
    .cop_wr_pend (cop_wr_pend),
    .mcu_rd_pend (mcu_rd_pend),
    .mcu_wr_pend (mcu_wr_pend),
    .cycle_start (cycle_start),
    .cycle_end   (cycle_end),
    .rom_hit     (rom_hit),
    .snes_dead   (snes_dead),
    .cpu_clk_raw (cpu_clk_raw),
    .grant_src   (grant_src),
    .grant_valid (grant_valid),
    .grant_write (grant_write),
    .capture     (capture),
    .mcu_done    (mcu_done),
    .cop_done    (cop_done)
  );

  rom_bus_mux rom_bus_mux_i (
    .grant_src     (grant_src),
    .grant_valid   (grant_valid),
    .grant_write   (grant_write),
    .mcu_addr_q    (mcu_addr_q),
    .cop_addr_q    (cop_addr_q),
    .mcu_wdata_q   (mcu_wdata_q),
    .cop_wdata_q   (cop_wdata_q),
    .addr_f        (addr_f),
    .rom_mask      (rom_mask),
    .romsel_n_f    (romsel_n_f),
    .rd_n_f        (rd_n_f),
    .rom_data_in   (rom_data_in),
    .rom_addr      (rom_addr),
    .rom_data_out  (rom_data_out),
    .rom_data_oe   (rom_data_oe),
    .rom_we_n      (rom_we_n),
    .rom_bhe_n     (rom_bhe_n),
    .rom_ble_n     (rom_ble_n),
    .rom_hit       (rom_hit),
    .rd_byte       (rd_byte),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe)
  );

endmodule

/* rom_ctrl/rom_bus_mux.sv */
`timescale 1ns/10ps

module rom_bus_mux import rom_pkg::*; (
  input  req_src_t   grant_src,
  input  logic       grant_valid,
  input  logic       grant_write,
  input  snes_addr_t mcu_addr_q,
  input  snes_addr_t cop_addr_q,
  input  byte_t      mcu_wdata_q,
  input  byte_t      cop_wdata_q,
  input  snes_addr_t addr_f,
  input  snes_addr_t rom_mask,
  input  logic       romsel_n_f,
  input  logic       rd_n_f,
  input  rom_word_t  rom_data_in,
  output rom_addr_t  rom_addr,
  output rom_word_t  rom_data_out,
  output logic       rom_data_oe,
  output logic       rom_we_n,
  output logic       rom_bhe_n,
  output logic       rom_ble_n,
  output logic       rom_hit,
  output byte_t      rd_byte,
  output byte_t      snes_data_out,
  output logic       snes_data_oe
);

  snes_addr_t mapped_addr;
  snes_addr_t req_addr;
  snes_addr_t sel_addr;
  byte_t      wr_byte;
  byte_t      lane_byte;
  logic       a0;
  logic       do_write;

  // fixed mapping, mask only
  assign mapped_addr = addr_f & rom_mask;
  assign rom_hit     = ~romsel_n_f;

  ////////////////////////////////////////////////////////////
  // address and lane select
  ////////////////////////////////////////////////////////////

  assign req_addr = (grant_src == cop) ? cop_addr_q : mcu_addr_q;
  assign wr_byte  = (grant_src == cop) ? cop_wdata_q : mcu_wdata_q;
  // granted requester beats the console
  assign sel_addr = grant_valid ? req_addr : mapped_addr;

  assign rom_addr  = sel_addr[23:1];
  assign a0        = sel_addr[0];
  assign rom_bhe_n = a0;
  assign rom_ble_n = ~a0;

  // odd byte on the low lane
  assign lane_byte     = a0 ? rom_data_in[7:0] : rom_data_in[15:8];
  assign rd_byte       = lane_byte;
  assign snes_data_out = lane_byte;

  ////////////////////////////////////////////////////////////
  // write path
  ////////////////////////////////////////////////////////////

  assign do_write     = grant_valid & grant_write;
  assign rom_we_n     = ~do_write;
  assign rom_data_oe  = do_write;
  assign rom_data_out = a0 ? {8'h00, wr_byte} : {wr_byte, 8'h00};

  // console read only while nobody else owns the port
  assign snes_data_oe = rom_hit & ~rd_n_f & ~grant_valid;

endmodule

/* rom_ctrl/rom_arbiter.sv */
`timescale 1ns/10ps

module rom_arbiter import rom_pkg::*; #(
  parameter int unsigned ROM_CYCLE_LEN = 6
) (
  input  logic     CLK2,
  input  logic     arst_n,
  input  logic     cop_active,
  input  logic     cop_rd_pend,
  input  logic     cop_wr_pend,
  input  logic     mcu_rd_pend,
  input  logic     mcu_wr_pend,
  input  logic     cycle_start,
  input  logic     cycle_end,
  input  logic     rom_hit,
  input  logic     snes_dead,
  input  logic     cpu_clk_raw,
  output req_src_t grant_src,
  output logic     grant_valid,
  output logic     grant_write,
  output logic     capture,
  output logic     mcu_done,
  output logic     cop_done
);

  localparam int DLY_W = (ROM_CYCLE_LEN < 1) ? 1 : $clog2(ROM_CYCLE_LEN + 1);
  localparam logic [DLY_W-1:0] DLY_LOAD = DLY_W'(ROM_CYCLE_LEN);

  arb_state_t       state;
  logic [DLY_W-1:0] dly;
  logic             free_strobe;
  logic             free_slot;

  ////////////////////////////////////////////////////////////
  // free slot detection
  ////////////////////////////////////////////////////////////

  // console cycle that is not going to rom leaves the bus idle
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~rom_hit;
    end
  end

  assign free_slot = cycle_end | free_strobe;

  ////////////////////////////////////////////////////////////
  // access fsm
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      state     <= st_idle;
      dly       <= '0;
      grant_src <= mcu;
    end else if (snes_dead && cpu_clk_raw) begin
      // console woke up, drop the access and retry later
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          // coprocessor first while it runs
          if (cop_active && (cop_rd_pend || cop_wr_pend)) begin
            state     <= cop_rd_pend ? st_cop_rd : st_cop_wr;
            dly       <= DLY_LOAD;
            grant_src <= cop;
          end else if ((free_slot || snes_dead) && (mcu_rd_pend || mcu_wr_pend)) begin
            state     <= mcu_rd_pend ? st_mcu_rd : st_mcu_wr;
            dly       <= DLY_LOAD;
            grant_src <= mcu;
          end
        end
        st_mcu_rd, st_mcu_wr, st_cop_rd, st_cop_wr: begin
          dly <= dly - 1'b1;
          if (dly == '0) state <= st_done;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // grant decode
  assign grant_valid = (state == st_mcu_rd) || (state == st_mcu_wr) ||
                       (state == st_cop_rd) || (state == st_cop_wr);
  assign grant_write = (state == st_mcu_wr) || (state == st_cop_wr);
  // sample on every read cycle
  assign capture     = (state == st_mcu_rd) || (state == st_cop_rd);

  assign mcu_done = (state == st_done) && (grant_src == mcu);
  assign cop_done = (state == st_done) && (grant_src == cop);

endmodule

/* rom_ctrl/rom_req_port.sv */
`timescale 1ns/10ps

module rom_req_port import rom_pkg::*; (
  input  logic       CLK2,
  input  logic       arst_n,
  input  logic       rrq,
  input  logic       wrq,
  input  snes_addr_t addr_in,
  input  byte_t      wdata,
  input  logic       done,
  input  logic       capture,
  input  byte_t      rd_byte,
  output logic       rd_pend,
  output logic       wr_pend,
  output logic       rdy,
  output snes_addr_t addr_q,
  output byte_t      wdata_q,
  output byte_t      rdata
);

  ////////////////////////////////////////////////////////////
  // pending flags and ready
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;
    end else if (rrq) begin
      rd_pend <= 1'b1;
      rdy     <= 1'b0;
    end else if (wrq) begin
      wr_pend <= 1'b1;
      rdy     <= 1'b0;
    end else if (done) begin
      // served, both flags drop
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;
    end
  end

  // request payload, held until the next request
  always_ff @(posedge CLK2) begin
    if (rrq || wrq) begin
      addr_q  <= addr_in;
      wdata_q <= wdata;
    end
  end

  // last capture of the grant wins
  always_ff @(posedge CLK2) begin
    if (capture) rdata <= rd_byte;
  end

endmodule

/* source/snes_liveness.sv */
`timescale 1ns/10ps

module snes_liveness import rom_pkg::*; #(
  parameter int unsigned DEAD_TIMEOUT = 96000
) (
  input  logic CLK2,
  input  logic arst_n,
  input  logic cpu_clk_raw,
  output logic snes_dead,
  output logic snes_reset_strobe
);

  // saturate a little past the threshold, one filter depth
  localparam int unsigned CNT_MAX = DEAD_TIMEOUT + SYNC_DEPTH;
  localparam int CNT_W = $clog2(CNT_MAX + 1);
  localparam logic [CNT_W-1:0] CNT_TOP  = CNT_W'(CNT_MAX);
  localparam logic [CNT_W-1:0] DEAD_LIM = CNT_W'(DEAD_TIMEOUT);

  logic [CNT_W-1:0] low_cnt;

  // cycles spent with the cpu clock low
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      low_cnt <= '0;
    end else if (cpu_clk_raw) begin
      low_cnt <= '0;
    end else if (low_cnt != CNT_TOP) begin
      low_cnt <= low_cnt + 1'b1;
    end
  end

  // console starts out dead until its clock shows up
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      snes_dead         <= 1'b1;
      snes_reset_strobe <= 1'b0;
    end else begin
      snes_reset_strobe <= 1'b0;
      if (cpu_clk_raw) begin
        snes_dead <= 1'b0;
        // first high clock after a dead spell
        if (snes_dead) snes_reset_strobe <= 1'b1;
      end else if (low_cnt > DEAD_LIM) begin
        snes_dead <= 1'b1;
      end
    end
  end

endmodule

/* source/snes_bus_sync.sv */
`timescale 1ns/10ps

module snes_bus_sync import rom_pkg::*; (
  input  logic       CLK2,
  input  logic       arst_n,
  input  snes_addr_t snes_addr,
  input  logic       snes_rd_n,
  input  logic       snes_wr_n,
  input  logic       snes_romsel_n,
  input  logic       snes_cpu_clk,
  output snes_addr_t addr_f,
  output logic       rd_n_f,
  output logic       wr_n_f,
  output logic       romsel_n_f,
  output logic       cpu_clk_f,
  output logic       cpu_clk_raw,
  output logic       cycle_start,
  output logic       cycle_end
);

  // width of the edge-detect window
  localparam int W = SYNC_DEPTH - 2;
  // clock low, then two stable high taps
  localparam logic [W-1:0] START_PAT = W'(2'b11);
  // clock high, then settled low
  localparam logic [W-1:0] END_PAT = {3'b111, {(W-3){1'b0}}};

  logic [SYNC_DEPTH-1:0] rd_sr;
  logic [SYNC_DEPTH-1:0] wr_sr;
  logic [SYNC_DEPTH-1:0] romsel_sr;
  logic [SYNC_DEPTH-1:0] clk_sr;
  snes_addr_t            addr_pipe [7];

  ////////////////////////////////////////////////////////////
  // strobe shift registers
  ////////////////////////////////////////////////////////////

  // strobes idle high, cpu clock idles low
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      rd_sr     <= '1;
      wr_sr     <= '1;
      romsel_sr <= '1;
      clk_sr    <= '0;
    end else begin
      rd_sr     <= {rd_sr[SYNC_DEPTH-2:0], snes_rd_n};
      wr_sr     <= {wr_sr[SYNC_DEPTH-2:0], snes_wr_n};
      romsel_sr <= {romsel_sr[SYNC_DEPTH-2:0], snes_romsel_n};
      clk_sr    <= {clk_sr[SYNC_DEPTH-2:0], snes_cpu_clk};
    end
  end

  // address rides a seven stage delay
  always_ff @(posedge CLK2) begin
    addr_pipe[0] <= snes_addr;
    for (int i = 1; i < 7; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
  end

  ////////////////////////////////////////////////////////////
  // filtered levels and edges
  ////////////////////////////////////////////////////////////

  // two adjacent taps must agree, kills one-cycle glitches
  assign rd_n_f     = rd_sr[2] & rd_sr[1];
  assign wr_n_f     = wr_sr[2] & wr_sr[1];
  assign romsel_n_f = romsel_sr[2] & romsel_sr[1];
  assign cpu_clk_f  = clk_sr[2] & clk_sr[1];
  assign addr_f     = addr_pipe[6] & addr_pipe[5];

  // unfiltered tap for the liveness timer
  assign cpu_clk_raw = clk_sr[1];

  assign cycle_start = (clk_sr[SYNC_DEPTH-1:2] & clk_sr[SYNC_DEPTH-2:1]) == START_PAT;
  assign cycle_end   = (clk_sr[SYNC_DEPTH-1:2] | clk_sr[SYNC_DEPTH-2:1]) == END_PAT;

endmodule

/* common/rom_pkg.sv */
package rom_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////

  // console address, one full 24-bit word
  typedef logic [23:0] snes_addr_t;
  // psram word address, byte select comes from bit 0 upstream
  typedef logic [22:0] rom_addr_t;
  typedef logic [15:0] rom_word_t;
  typedef logic [7:0]  byte_t;

  // length of each strobe filter shift register
  parameter int SYNC_DEPTH = 8;

  ////////////////////////////////////////////////////////////
  // arbiter encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [7:0] {
    st_idle   = 8'h00,
    st_mcu_rd = 8'h01,
    st_mcu_wr = 8'h02,
    st_cop_rd = 8'h03,
    st_cop_wr = 8'h04,
    st_done   = 8'h05
  } arb_state_t;

  // who owns the rom port during a grant
  typedef enum logic [7:0] {
    mcu = 8'h00,
    cop = 8'h01
  } req_src_t;

endpackage
